// File: hdl/motor_pkg.sv
package motor_pkg;

    // Widths that carry a meaning
    typedef logic [7:0]         byte_t;   // One UART byte
    typedef logic signed [15:0] duty_t;   // Signed motor duty
    typedef logic [15:0]        count_t;  // PSC, CCR and counter values
    typedef logic [1:0]         dir_t;    // 01 forward, 10 reverse, 00 stop

    // Command frame parser
    typedef enum logic [1:0] {
        idle,
        high_byte,
        low_byte
    } parse_state_t;

    // Header bytes, also sent back as the acknowledge
    localparam byte_t hdr_duty0 = 8'hAA;  // Motor 0 duty
    localparam byte_t hdr_duty1 = 8'hBB;  // Motor 1 duty
    localparam byte_t hdr_psc   = 8'hCC;
    localparam byte_t hdr_ccr   = 8'hDD;
    localparam byte_t hdr_query = 8'hEE;  // Single byte, no payload

    // Register values after reset
    localparam count_t psc_default = 16'd99;
    localparam count_t ccr_default = 16'd999;

endpackage

// File: hdl/uart_rx.sv
module uart_rx
    import motor_pkg::*;
#(
    parameter int clks_per_bit = 868
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx_line,
    output byte_t rx_byte,
    output logic  rx_valid
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t        state;
    logic             sync_q1;
    logic             sync_q2;
    logic [cnt_w-1:0] cnt;
    logic [2:0]       bit_idx;
    byte_t            shift;

    wire half_bit = (cnt == cnt_w'(clks_per_bit / 2 - 1));
    wire full_bit = (cnt == cnt_w'(clks_per_bit - 1));

    // Two flops against metastability, line idles high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= 1'b1;
            sync_q2 <= 1'b1;
        end else begin
            sync_q1 <= rx_line;
            sync_q2 <= sync_q1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= rx_idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                rx_idle: begin
                    cnt <= '0;
                    if (!sync_q2) state <= rx_start;  // Falling edge of start bit
                end
                rx_start: if (half_bit) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= sync_q2 ? rx_idle : rx_data;  // Glitch rejected
                end
                rx_data: if (full_bit) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= rx_stop;
                end
                rx_stop: if (full_bit) begin
                    rx_valid <= sync_q2;  // Low stop bit drops the byte
                    state    <= rx_idle;
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // Data path, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == rx_data && full_bit) shift <= {sync_q2, shift[7:1]};
        if (state == rx_stop && full_bit) rx_byte <= shift;
    end

endmodule

// File: hdl/cmd_parser.sv
module cmd_parser
    import motor_pkg::*;
#(
    parameter int ack_depth = 4
) (
    input  logic   clk,
    input  logic   rst_n,
    input  byte_t  rx_byte,
    input  logic   rx_valid,
    input  logic   credit_return,
    output logic   ack_push,
    output byte_t  ack_byte,
    output duty_t  duty0,
    output duty_t  duty1,
    output count_t psc,
    output count_t ccr
);

    localparam int crd_w = $clog2(ack_depth + 1);

    parse_state_t     state;
    byte_t            cmd_hdr;   // Header of the frame in progress
    byte_t            high_q;    // Stored high payload byte
    logic [crd_w-1:0] credits;

    // Limit a requested duty to plus or minus the period
    function automatic duty_t clamp_duty(input duty_t req, input count_t lim);
        logic signed [16:0] req_x;
        logic signed [16:0] lim_x;
        req_x = req;
        lim_x = {1'b0, lim};
        if (req_x > lim_x)
            clamp_duty = duty_t'(lim_x);
        else if (req_x < -lim_x)
            clamp_duty = duty_t'(-lim_x);
        else
            clamp_duty = req;
    endfunction

    wire   query_hit  = rx_valid && (state == idle) && (rx_byte == hdr_query);
    wire   frame_done = rx_valid && (state == low_byte);
    wire   want_ack   = query_hit || frame_done;
    wire   do_push    = want_ack && (credits != '0);  // Dropped when no credit is left
    wire   [15:0] payload = {high_q, rx_byte};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            cmd_hdr <= '0;
            duty0   <= '0;
            duty1   <= '0;
            psc     <= psc_default;
            ccr     <= ccr_default;
        end else if (rx_valid) begin
            case (state)
                idle: begin
                    cmd_hdr <= rx_byte;
                    // Query and unknown headers stay here
                    if (rx_byte inside {hdr_duty0, hdr_duty1, hdr_psc, hdr_ccr})
                        state <= high_byte;
                end
                high_byte: state <= low_byte;
                low_byte: begin
                    state <= idle;
                    case (cmd_hdr)
                        hdr_duty0: duty0 <= clamp_duty(duty_t'(payload), ccr);
                        hdr_duty1: duty1 <= clamp_duty(duty_t'(payload), ccr);
                        hdr_psc:   psc   <= payload;
                        hdr_ccr:   ccr   <= payload;
                        default:   ;
                    endcase
                end
                default: state <= idle;
            endcase
        end
    end

    // Credit count mirrors free FIFO slots
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits  <= crd_w'(ack_depth);
            ack_push <= 1'b0;
        end else begin
            ack_push <= do_push;
            credits  <= credits - crd_w'(do_push) + crd_w'(credit_return);
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && state == high_byte) high_q <= rx_byte;
        if (want_ack) ack_byte <= query_hit ? hdr_query : cmd_hdr;
    end

    // Returns from the FIFO never outnumber the pushes
    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= crd_w'(ack_depth));

endmodule

// File: hdl/ack_fifo.sv
module ack_fifo
    import motor_pkg::*;
#(
    parameter int ack_depth = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  ack_push,
    input  byte_t ack_byte,
    input  logic  tx_pop,
    output byte_t tx_byte,
    output logic  tx_avail,
    output logic  credit_return
);

    localparam int ptr_w = (ack_depth > 1) ? $clog2(ack_depth) : 1;
    localparam int cnt_w = $clog2(ack_depth + 1);

    byte_t            mem [ack_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;   // Occupancy

    wire full = (count == cnt_w'(ack_depth));

    // Pointer advance with wrap for any depth
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        next_ptr = (ptr == ptr_w'(ack_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (ack_push) wr_ptr <= next_ptr(wr_ptr);
            if (tx_pop)   rd_ptr <= next_ptr(rd_ptr);
            count         <= count + cnt_w'(ack_push) - cnt_w'(tx_pop);
            credit_return <= tx_pop;  // Slot is free once the pop lands
        end
    end

    always_ff @(posedge clk) begin
        if (ack_push) mem[wr_ptr] <= ack_byte;
    end

    assign tx_byte  = mem[rd_ptr];
    assign tx_avail = (count != '0);

    // Parser credits must keep the queue from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        ack_push |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        tx_pop |-> tx_avail);

endmodule

// File: hdl/uart_tx.sv
module uart_tx
    import motor_pkg::*;
#(
    parameter int clks_per_bit = 868
) (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t tx_byte,
    input  logic  tx_avail,
    output logic  tx_pop,
    output logic  tx_line
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

    tx_state_t        state;
    logic [cnt_w-1:0] cnt;      // Bit-time counter
    logic [2:0]       bit_idx;
    byte_t            shift;

    wire bit_end = (cnt == cnt_w'(clks_per_bit - 1));

    assign tx_pop = (state == tx_idle) && tx_avail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= tx_idle;
            cnt     <= '0;
            bit_idx <= '0;
            tx_line <= 1'b1;  // Idle level
        end else begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                tx_idle: begin
                    cnt <= '0;
                    if (tx_avail) begin
                        tx_line <= 1'b0;   // Start bit
                        state   <= tx_start;
                    end
                end
                tx_start: if (bit_end) begin
                    tx_line <= shift[0];
                    bit_idx <= '0;
                    state   <= tx_data;
                end
                tx_data: if (bit_end) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        tx_line <= 1'b1;   // Stop bit
                        state   <= tx_stop;
                    end else begin
                        tx_line <= shift[1];
                    end
                end
                tx_stop: if (bit_end) state <= tx_idle;
                default: state <= tx_idle;
            endcase
        end
    end

    // Shift register, LSB goes out first
    always_ff @(posedge clk) begin
        if (tx_pop)
            shift <= tx_byte;
        else if (state == tx_data && bit_end)
            shift <= shift >> 1;
    end

endmodule

// File: hdl/pwm_channel.sv
module pwm_channel
    import motor_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  count_t psc,
    input  count_t ccr,
    input  duty_t  duty,
    output logic   pwm,
    output dir_t   dir
);

    count_t pre_cnt;    // Prescaler, 0 to psc
    count_t per_cnt;    // Period counter, 0 to ccr
    count_t duty_mag;

    // Compare with >= so a smaller new limit cannot strand a counter
    wire pre_wrap = (pre_cnt >= psc);
    wire per_wrap = (per_cnt >= ccr);

    // Unsigned magnitude, -32768 maps to 32768
    assign duty_mag = duty[15] ? count_t'(-duty) : count_t'(duty);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= '0;
            per_cnt <= '0;
        end else begin
            pre_cnt <= pre_wrap ? '0 : pre_cnt + 1'b1;
            if (pre_wrap)
                per_cnt <= per_wrap ? '0 : per_cnt + 1'b1;
        end
    end

    // Registered outputs keep the motor pins glitch free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm <= 1'b0;
            dir <= 2'b00;
        end else begin
            pwm <= (per_cnt < duty_mag);
            if (duty == '0)
                dir <= 2'b00;      // Stop
            else if (duty[15])
                dir <= 2'b10;      // Reverse
            else
                dir <= 2'b01;      // Forward
        end
    end

endmodule

// File: hdl/motor_ctrl_top.sv
module motor_ctrl_top
    import motor_pkg::*;
#(
    parameter int clks_per_bit = 868,
    parameter int ack_depth    = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx_line,
    output logic       uart_tx_line,
    output logic [1:0] pwm_out,
    output logic [3:0] motor_in    // Motor 1 pair in bits 3:2
);

    byte_t  rx_byte;
    logic   rx_valid;
    logic   ack_push;
    byte_t  ack_byte;
    logic   credit_return;
    byte_t  tx_byte;
    logic   tx_avail;
    logic   tx_pop;
    duty_t  duty0;
    duty_t  duty1;
    count_t psc;
    count_t ccr;

    uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (
        .clk(clk), .rst_n(rst_n), .rx_line(uart_rx_line),
        .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    cmd_parser #(.ack_depth(ack_depth)) u_cmd_parser (
        .clk(clk), .rst_n(rst_n), .rx_byte(rx_byte), .rx_valid(rx_valid),
        .credit_return(credit_return), .ack_push(ack_push), .ack_byte(ack_byte),
        .duty0(duty0), .duty1(duty1), .psc(psc), .ccr(ccr)
    );

    ack_fifo #(.ack_depth(ack_depth)) u_ack_fifo (
        .clk(clk), .rst_n(rst_n), .ack_push(ack_push), .ack_byte(ack_byte),
        .tx_pop(tx_pop), .tx_byte(tx_byte), .tx_avail(tx_avail),
        .credit_return(credit_return)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx (
        .clk(clk), .rst_n(rst_n), .tx_byte(tx_byte), .tx_avail(tx_avail),
        .tx_pop(tx_pop), .tx_line(uart_tx_line)
    );

    pwm_channel u_pwm0 (
        .clk(clk), .rst_n(rst_n), .psc(psc), .ccr(ccr), .duty(duty0),
        .pwm(pwm_out[0]), .dir(motor_in[1:0])
    );

    pwm_channel u_pwm1 (
        .clk(clk), .rst_n(rst_n), .psc(psc), .ccr(ccr), .duty(duty1),
        .pwm(pwm_out[1]), .dir(motor_in[3:2])
    );

endmodule

// File: verif/motor_checker.sv
module motor_checker
    import motor_pkg::*;
#(
    parameter int bit_clks = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_tx_line,
    input  logic [1:0] pwm_out,
    input  logic [3:0] motor_in,
    output int         passed,
    output int         failed
);

    byte_t rx_q[$];         // Decoded acknowledge bytes, oldest first
    byte_t data;
    int    frame_errs = 0;
    int    n_pass = 0;
    int    n_fail = 0;

    assign passed = n_pass;
    assign failed = n_fail;

    // UART decoder, samples each bit near its middle
    always begin
        @(posedge clk);
        if (rst_n && uart_tx_line === 1'b0) begin
            repeat (bit_clks / 2 - 1) @(posedge clk);
            for (int i = 0; i < 8; i++) begin
                repeat (bit_clks) @(posedge clk);
                data = {uart_tx_line, data[7:1]};  // LSB first
            end
            repeat (bit_clks) @(posedge clk);
            if (uart_tx_line !== 1'b1)
                frame_errs++;
            else
                rx_q.push_back(data);
        end
    end

    // Acks in order, then direction pins, then PWM high time over one period
    task automatic check_row(input string name, input logic [31:0] acks, input int nack,
                             input logic [3:0] mi, input logic ch, input int high,
                             input int window);
        int    errs;
        int    actual;
        byte_t got;
        byte_t want;
        errs = 0;
        while (rx_q.size() < nack) @(posedge clk);
        for (int k = 0; k < nack; k++) begin
            got  = rx_q.pop_front();
            want = byte_t'(acks >> (8 * (nack - 1 - k)));
            if (got !== want) begin
                $display("ERROR %s ack %0d expected %02h actual %02h", name, k, want, got);
                errs++;
            end
        end
        @(posedge clk);
        if (motor_in !== mi) begin
            $display("ERROR %s motor_in expected %04b actual %04b", name, mi, motor_in);
            errs++;
        end
        actual = 0;
        repeat (window) begin
            @(posedge clk);
            if (pwm_out[ch] === 1'b1) actual++;
        end
        if (actual != high) begin
            $display("ERROR %s pwm high count expected %0d actual %0d", name, high, actual);
            errs++;
        end
        if (errs == 0) begin
            n_pass++;
            $display("test %-16s ok", name);
        end else begin
            n_fail++;
            $display("test %-16s failed with %0d mismatches", name, errs);
        end
    endtask

    // Nothing more may come out of the transmitter
    task automatic check_quiet(input int cycles);
        repeat (cycles) @(posedge clk);
        if (rx_q.size() != 0 || frame_errs != 0) begin
            n_fail++;
            $display("test quiet_line       failed: %0d stray bytes and %0d framing errors",
                     rx_q.size(), frame_errs);
        end else begin
            n_pass++;
            $display("test quiet_line       ok");
        end
    endtask

endmodule

// File: verif/tb_motor_ctrl.sv
module tb_motor_ctrl
    import motor_pkg::*;
();

    localparam int bit_clks = 8;
    localparam int max_rows = 16;

    logic       clk;
    logic       rst_n;
    logic       uart_rx_line;
    logic       uart_tx_line;
    logic [1:0] pwm_out;
    logic [3:0] motor_in;
    int         n_passed;
    int         n_failed;
    int         cycles = 0;
    int         limit = 0;

    // Stimulus table, one row per test
    string       row_name   [max_rows];
    logic [63:0] row_frame  [max_rows];  // First byte in the highest used byte
    int          row_nframe [max_rows];
    logic [31:0] row_acks   [max_rows];
    int          row_nack   [max_rows];
    logic [3:0]  row_mi     [max_rows];
    logic        row_ch     [max_rows];
    int          row_high   [max_rows];
    int          row_window [max_rows];
    int          n_rows = 0;

    // Reference state of the motor registers
    int          m_duty0 = 0;
    int          m_duty1 = 0;
    int          m_psc = 99;
    int          m_ccr = 999;
    logic [31:0] rng = 32'd55;

    motor_ctrl_top #(.clks_per_bit(bit_clks), .ack_depth(4)) DUT (
        .clk(clk), .rst_n(rst_n), .uart_rx_line(uart_rx_line),
        .uart_tx_line(uart_tx_line), .pwm_out(pwm_out), .motor_in(motor_in)
    );

    motor_checker #(.bit_clks(bit_clks)) CHK (
        .clk(clk), .rst_n(rst_n), .uart_tx_line(uart_tx_line), .pwm_out(pwm_out),
        .motor_in(motor_in), .passed(n_passed), .failed(n_failed)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int limit_duty(input int req, input int lim);
        if (req > lim) return lim;
        if (req < -lim) return -lim;
        return req;
    endfunction

    function automatic int magnitude_of(input int d);
        return (d < 0) ? -d : d;
    endfunction

    function automatic logic [1:0] direction_of(input int d);
        if (d > 0) return 2'b01;
        if (d < 0) return 2'b10;
        return 2'b00;
    endfunction

    // Expectations come from the reference state after the row's frames
    task automatic add_row(input string name, input logic [63:0] frame, input int nframe,
                           input logic [31:0] acks, input int nack, input logic ch);
        int mag;
        mag = ch ? magnitude_of(m_duty1) : magnitude_of(m_duty0);
        row_name[n_rows]   = name;
        row_frame[n_rows]  = frame;
        row_nframe[n_rows] = nframe;
        row_acks[n_rows]   = acks;
        row_nack[n_rows]   = nack;
        row_ch[n_rows]     = ch;
        row_mi[n_rows]     = {direction_of(m_duty1), direction_of(m_duty0)};
        row_high[n_rows]   = (m_psc + 1) * ((mag < m_ccr) ? mag : m_ccr);
        row_window[n_rows] = (m_psc + 1) * (m_ccr + 1);
        n_rows++;
    endtask

    task automatic add_duty(input string name, input logic motor, input int value);
        logic [15:0] raw;
        raw = value[15:0];
        if (motor)
            m_duty1 = limit_duty(value, m_ccr);
        else
            m_duty0 = limit_duty(value, m_ccr);
        add_row(name, {40'h0, motor ? 8'hBB : 8'hAA, raw}, 3,
                motor ? 32'hBB : 32'hAA, 1, motor);
    endtask

    task automatic build_table();
        add_row("reset_idle", 64'h0, 0, 32'h0, 0, 1'b0);
        m_psc = 0;
        m_ccr = 9;
        add_row("set_period", 64'hCC_0000_DD_0009, 6, 32'hCC_DD, 2, 1'b0);
        add_row("unknown_hdr", 64'h5A_EE, 2, 32'hEE, 1, 1'b0);  // 5A gets no answer
        add_duty("duty0_six", 1'b0, 6);
        add_duty("duty0_zero", 1'b0, 0);
        add_duty("duty1_clamp_pos", 1'b1, 300);
        add_duty("duty0_clamp_neg", 1'b0, -300);
        add_row("query_burst", 64'hEE_EE_EE_EE, 4, 32'hEE_EE_EE_EE, 4, 1'b0);
        m_psc = 1;
        add_row("psc_one", 64'hCC_0001, 3, 32'hCC, 1, 1'b0);
        for (int r = 0; r < 4; r++) begin
            rng = xorshift(rng);
            add_duty($sformatf("random_%0d", r), r[0], int'(rng % 33) - 16);
        end
    endtask

    // One 8N1 byte, each bit changes just after a rising edge
    task automatic send_byte(input byte_t b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            uart_rx_line = bits[0];
            bits = bits >> 1;
            repeat (bit_clks - 1) @(posedge clk);
        end
    endtask

    initial begin
        int budget;
        rst_n = 1'b0;
        uart_rx_line = 1'b1;
        build_table();
        budget = 20 * 10 * bit_clks + 500;
        for (int i = 0; i < n_rows; i++)
            budget += (row_nframe[i] + row_nack[i]) * 10 * bit_clks + row_window[i] + 100;
        limit = budget;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            for (int k = 0; k < row_nframe[i]; k++)
                send_byte(byte_t'(row_frame[i] >> (8 * (row_nframe[i] - 1 - k))));
            CHK.check_row(row_name[i], row_acks[i], row_nack[i], row_mi[i], row_ch[i],
                          row_high[i], row_window[i]);
        end
        CHK.check_quiet(20 * bit_clks);
        $display("Summary: %0d tests passed, %0d failed", n_passed, n_failed);
        if (n_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog against a DUT that never answers
    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the acknowledges or measurements never finished",
                 cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: motor_ctrl.f
hdl/motor_pkg.sv
hdl/uart_rx.sv
hdl/cmd_parser.sv
hdl/ack_fifo.sv
hdl/uart_tx.sv
hdl/pwm_channel.sv
hdl/motor_ctrl_top.sv
verif/motor_checker.sv
verif/tb_motor_ctrl.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module tb_motor_ctrl -f motor_ctrl.f -o sim_motor_ctrl &&
./obj_dir/sim_motor_ctrl | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
